// ==== sim.f ====
source/vga_pkg.sv
source/vga_sync.sv
source/sync_fifo.sv
source/vga_fb_pixel_stream.sv
source/fb_sram.sv
source/vga_fb_top.sv
verification/vga_fb_checker.sv
verification/vga_fb_sva.sv
verification/vga_fb_tb.sv

// ==== Bender.yml ====
package:
  name: vga_fb

sources:
  - source/vga_pkg.sv
  - source/vga_sync.sv
  - source/sync_fifo.sv
  - source/vga_fb_pixel_stream.sv
  - source/fb_sram.sv
  - source/vga_fb_top.sv
  - target: simulation
    files:
      - verification/vga_fb_checker.sv
      - verification/vga_fb_sva.sv
      - verification/vga_fb_tb.sv

// ==== verification/vga_fb_tb.sv ====
`timescale 1ns/1ps

module vga_fb_tb;

  localparam int FRAME_TIMEOUT    = 8000;
  localparam int QUIET_CYCLES     = 20;
  localparam int QUIET_TIMEOUT    = 200;
  localparam int NUM_PHASES       = 4;

  typedef struct packed {
    logic       random_fill;
    logic [6:0] duty;
    logic [3:0] frames;
    logic       scan_writes;
  } phase_t;

  // fill mode, enable duty in percent, frames, writes during scan
  localparam phase_t PHASES [NUM_PHASES] = '{
    '{1'b0, 7'd100, 4'd2, 1'b0},
    '{1'b1, 7'd100, 4'd1, 1'b1},
    '{1'b1, 7'd30,  4'd1, 1'b1},
    '{1'b0, 7'd70,  4'd2, 1'b1}
  };

  logic                clk;
  logic                reset;
  logic                enable;
  logic                valid;
  vga_pkg::pixel_out_t pixel;
  logic                wr_en;
  vga_pkg::fb_addr_t   wr_addr;
  vga_pkg::color_t     wr_data;

  int            mismatch_count;
  int            pixel_count;
  int            frame_count;
  vga_pkg::row_t exp_row;
  int            tb_errors;
  logic          timed_out;

  vga_fb_top dut (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .valid  (valid),
    .pixel  (pixel),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  vga_fb_checker pixel_check (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .valid      (valid),
    .pixel      (pixel),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .error_count(mismatch_count),
    .pixel_count(pixel_count),
    .frame_count(frame_count),
    .exp_row    (exp_row)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // every bit of the address shows up in the word
  function automatic vga_pkg::color_t address_pattern(input vga_pkg::fb_addr_t addr);
    return vga_pkg::color_t'({addr[3:0] ^ addr[7:4], addr}) ^ 12'h3c5;
  endfunction

  task automatic wait_for_quiet();
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < QUIET_CYCLES && !timed_out) begin
      @(negedge clk);
      cycles++;
      quiet = valid ? 0 : quiet + 1;
      if (cycles > QUIET_TIMEOUT) begin
        $display("ERROR: stream kept emitting pixels %0d cycles after enable fell", cycles);
        tb_errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic fill_frame(input logic random_fill);
    for (int a = 0; a < vga_pkg::FB_WORDS; a++) begin
      @(negedge clk);
      wr_en   = 1'b1;
      wr_addr = vga_pkg::fb_addr_t'(a);
      wr_data = random_fill ? vga_pkg::color_t'($urandom) : address_pattern(wr_addr);
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic run_frames(input int duty, input int frames, input logic scan_writes);
    int            target;
    int            cycles;
    vga_pkg::row_t write_row;
    target = frame_count + frames;
    cycles = 0;
    while (frame_count < target && !timed_out) begin
      @(negedge clk);
      cycles++;
      enable = (($urandom % 100) < duty);
      wr_en  = 1'b0;
      // write a few rows ahead of the scan, never into reads in flight
      if (scan_writes && (cycles % 8 == 0)) begin
        write_row = vga_pkg::row_t'((int'(exp_row) + 4) % vga_pkg::V_VISIBLE);
        wr_en     = 1'b1;
        wr_addr   = vga_pkg::fb_addr_t'(write_row * vga_pkg::H_VISIBLE + $urandom % 16);
        wr_data   = vga_pkg::color_t'($urandom);
      end
      if (cycles > (frames + 1) * FRAME_TIMEOUT) begin
        $display("ERROR: %0d frames did not complete within %0d cycles", frames, cycles);
        tb_errors++;
        timed_out = 1'b1;
      end
    end
    wr_en = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h19f9));
    reset        = 1'b1;
    enable       = 1'b0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    tb_errors    = 0;
    timed_out    = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < NUM_PHASES; i++) begin
      enable = 1'b0;
      wait_for_quiet();
      if (timed_out) begin
        break;
      end
      fill_frame(PHASES[i].random_fill);
      run_frames(PHASES[i].duty, PHASES[i].frames, PHASES[i].scan_writes);
      if (timed_out) begin
        break;
      end
    end
    enable = 1'b0;
    wait_for_quiet();

    $display("summary: %0d pixels, %0d frames, %0d mismatches, %0d assertion errors, %0d tb errors",
             pixel_count, frame_count, mismatch_count, dut.stream.sva.assert_errors, tb_errors);
    if (mismatch_count + tb_errors + dut.stream.sva.assert_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verification/vga_fb_sva.sv ====
`timescale 1ns/1ps

module vga_fb_sva (
  input logic                clk,
  input logic                reset,
  input vga_pkg::fb_rd_req_t rd_req,
  input logic                arready,
  input logic                valid,
  input vga_pkg::pixel_out_t pixel,
  input logic                rready
);

  int assert_errors;

  // a waiting request keeps valid and address
  assert property (@(posedge clk) disable iff (reset)
    rd_req.arvalid && !arready |=> rd_req.arvalid && $stable(rd_req.araddr))
  else begin
    $error("arvalid dropped or araddr moved before arready");
    assert_errors++;
  end

  assert property (@(posedge clk) disable iff (reset)
    valid && !pixel.ctx.visible |-> pixel.color == '0)
  else begin
    $error("blank pixel carries a nonzero color");
    assert_errors++;
  end

  assert property (@(posedge clk) disable iff (reset) rready)
  else begin
    $error("rready low out of reset");
    assert_errors++;
  end

endmodule

bind vga_fb_pixel_stream vga_fb_sva sva (
  .clk    (clk),
  .reset  (reset),
  .rd_req (rd_req),
  .arready(arready),
  .valid  (valid),
  .pixel  (pixel),
  .rready (rready)
);

// ==== verification/vga_fb_checker.sv ====
`timescale 1ns/1ps

module vga_fb_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  logic                valid,
  input  vga_pkg::pixel_out_t pixel,
  input  logic                wr_en,
  input  vga_pkg::fb_addr_t   wr_addr,
  input  vga_pkg::color_t     wr_data,
  output int                  error_count,
  output int                  pixel_count,
  output int                  frame_count,
  output vga_pkg::row_t       exp_row
);

  // shadow of the frame buffer, fed from the write port
  vga_pkg::color_t   fb_model [vga_pkg::FB_WORDS];
  vga_pkg::col_t     exp_col;
  vga_pkg::fb_addr_t exp_addr;
  logic              exp_visible;
  logic              exp_hsync;
  logic              exp_vsync;
  logic              enable_seen;
  int                since_enable;

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_pixel();
    exp_visible = (exp_col < vga_pkg::H_VISIBLE) && (exp_row < vga_pkg::V_VISIBLE);
    // sync pulses sit after the front porch and are active low
    exp_hsync = !((exp_col >= vga_pkg::H_VISIBLE + vga_pkg::H_FRONT_PORCH) &&
                  (exp_col < vga_pkg::H_VISIBLE + vga_pkg::H_FRONT_PORCH +
                             vga_pkg::H_SYNC_PULSE));
    exp_vsync = !((exp_row >= vga_pkg::V_VISIBLE + vga_pkg::V_FRONT_PORCH) &&
                  (exp_row < vga_pkg::V_VISIBLE + vga_pkg::V_FRONT_PORCH +
                             vga_pkg::V_SYNC_PULSE));
    exp_addr = vga_pkg::fb_addr_t'(exp_row * vga_pkg::H_VISIBLE + exp_col);
    check_value("pixel.ctx.visible", 16'(exp_visible), 16'(pixel.ctx.visible));
    check_value("pixel.ctx.hsync", 16'(exp_hsync), 16'(pixel.ctx.hsync));
    check_value("pixel.ctx.vsync", 16'(exp_vsync), 16'(pixel.ctx.vsync));
    if (exp_visible) begin
      check_value("pixel.ctx.addr", 16'(exp_addr), 16'(pixel.ctx.addr));
      check_value("pixel.color", 16'(fb_model[exp_addr]), 16'(pixel.color));
    end else begin
      check_value("pixel.color", 16'h0, 16'(pixel.color));
    end
  endtask

  task automatic advance_position();
    if (exp_col == vga_pkg::H_WHOLE_LINE - 1) begin
      exp_col = '0;
      if (exp_row == vga_pkg::V_WHOLE_FRAME - 1) begin
        exp_row = '0;
        frame_count++;
      end else begin
        exp_row = exp_row + 1'b1;
      end
    end else begin
      exp_col = exp_col + 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      exp_col      = '0;
      exp_row      = '0;
      enable_seen  = 1'b0;
      since_enable = 0;
      pixel_count  = 0;
      frame_count  = 0;
    end else begin
      if (valid) begin
        if (!enable_seen) begin
          $display("ERROR at %0d ns: valid rose before enable was ever high", $time);
          error_count++;
        end else if (pixel_count == 0 && since_enable < 4) begin
          $display("ERROR at %0d ns: first pixel came %0d clocks after enable, too early",
                   $time, since_enable);
          error_count++;
        end
        check_pixel();
        pixel_count++;
        advance_position();
      end
      // compare first, so a write lands only for later reads
      if (wr_en) begin
        fb_model[wr_addr] = wr_data;
      end
      if (enable_seen) begin
        since_enable++;
      end
      if (enable) begin
        enable_seen = 1'b1;
      end
    end
  end

endmodule

// ==== source/vga_fb_top.sv ====
`timescale 1ns/1ps

module vga_fb_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  output logic                valid,
  output vga_pkg::pixel_out_t pixel,
  input  logic                wr_en,
  input  vga_pkg::fb_addr_t   wr_addr,
  input  vga_pkg::color_t     wr_data
);

  // frame-buffer read channel
  vga_pkg::fb_rd_req_t rd_req;
  vga_pkg::fb_rd_rsp_t rd_rsp;
  logic                arready;
  logic                rready;

  vga_fb_pixel_stream stream (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .valid  (valid),
    .pixel  (pixel),
    .rd_req (rd_req),
    .arready(arready),
    .rd_rsp (rd_rsp),
    .rready (rready)
  );

  fb_sram fb (
    .clk    (clk),
    .reset  (reset),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_req (rd_req),
    .arready(arready),
    .rd_rsp (rd_rsp),
    .rready (rready)
  );

endmodule

// ==== source/fb_sram.sv ====
`timescale 1ns/1ps

module fb_sram (
  input  logic                clk,
  input  logic                reset,
  input  logic                wr_en,
  input  vga_pkg::fb_addr_t   wr_addr,
  input  vga_pkg::color_t     wr_data,
  input  vga_pkg::fb_rd_req_t rd_req,
  output logic                arready,
  output vga_pkg::fb_rd_rsp_t rd_rsp,
  input  logic                rready
);

  vga_pkg::color_t mem [vga_pkg::FB_WORDS];

  logic            valid_s1;
  logic            valid_s2;
  vga_pkg::color_t data_s1;
  vga_pkg::color_t data_s2;

  // the pipeline only moves while the master takes responses
  assign arready = rready;

  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr < vga_pkg::FB_WORDS)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else if (rready) begin
      valid_s1 <= rd_req.arvalid;
      valid_s2 <= valid_s1;
    end
  end

  // same-cycle write still returns the old word here
  always_ff @(posedge clk) begin
    if (rready) begin
      data_s1 <= mem[rd_req.araddr];
      data_s2 <= data_s1;
    end
  end

  assign rd_rsp.rvalid = valid_s2;
  assign rd_rsp.rdata  = data_s2;

endmodule

// ==== source/vga_fb_pixel_stream.sv ====
`timescale 1ns/1ps

module vga_fb_pixel_stream (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  output logic                valid,
  output vga_pkg::pixel_out_t pixel,
  output vga_pkg::fb_rd_req_t rd_req,
  input  logic                arready,
  input  vga_pkg::fb_rd_rsp_t rd_rsp,
  output logic                rready
);

  typedef enum logic {
    IDLE,
    READING
  } rd_state_t;

  // raster position
  logic              raster_visible;
  logic              raster_hsync;
  logic              raster_vsync;
  vga_pkg::col_t     raster_column;
  vga_pkg::row_t     raster_row;
  logic              raster_inc;
  vga_pkg::fb_addr_t raster_addr;

  // stage one, one clock behind the raster
  logic                enable_p1;
  logic                inc_p1;
  vga_pkg::pixel_ctx_t ctx_p1;

  // read issue
  rd_state_t         state;
  rd_state_t         next_state;
  logic              read_start;
  logic              read_accepted;
  logic              read_done;
  vga_pkg::fb_addr_t araddr_q;

  // context fifo
  logic                fifo_almost_full;
  logic                fifo_empty;
  logic                fifo_r_inc;
  vga_pkg::pixel_ctx_t fifo_head;

  // a visible position moves on only once its read is started
  assign raster_inc = read_start ||
                      (!fifo_almost_full && !raster_visible && enable);

  vga_sync sync (
    .clk    (clk),
    .reset  (reset),
    .enable (raster_inc),
    .visible(raster_visible),
    .hsync  (raster_hsync),
    .vsync  (raster_vsync),
    .column (raster_column),
    .row    (raster_row)
  );

  assign raster_addr = vga_pkg::fb_addr_t'(raster_row * vga_pkg::H_VISIBLE + raster_column);

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_p1 <= 1'b0;
      inc_p1    <= 1'b0;
    end else begin
      enable_p1 <= enable;
      inc_p1    <= raster_inc;
    end
  end

  always_ff @(posedge clk) begin
    ctx_p1.visible <= raster_visible;
    ctx_p1.hsync   <= raster_hsync;
    ctx_p1.vsync   <= raster_vsync;
    ctx_p1.addr    <= raster_addr;
  end

  assign read_accepted = rd_req.arvalid && arready;
  assign read_done     = rd_rsp.rvalid && rready;

  always_comb begin
    next_state = state;
    read_start = 1'b0;

    // stage one only matches the raster when the raster held last clock
    if (enable_p1 && ctx_p1.visible && !inc_p1 && !fifo_almost_full) begin
      if (state == IDLE || read_accepted) begin
        read_start = 1'b1;
      end
    end

    case (state)
      IDLE: begin
        if (read_start) begin
          next_state = READING;
        end
      end
      READING: begin
        if (read_accepted && !read_start) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (read_start) begin
      araddr_q <= ctx_p1.addr;
    end
  end

  // arvalid is high for as long as a request waits for arready
  assign rd_req.arvalid = (state == READING);
  assign rd_req.araddr  = araddr_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      rready <= 1'b1;
    end
  end

  // w_full left open, almost-full stalls the raster first
  sync_fifo ctx_fifo (
    .clk          (clk),
    .reset        (reset),
    .w_inc        (inc_p1),
    .w_data       (ctx_p1),
    .w_full       (),
    .w_almost_full(fifo_almost_full),
    .r_inc        (fifo_r_inc),
    .r_data       (fifo_head),
    .r_empty      (fifo_empty)
  );

  // blank pixels drain at once, visible ones wait for their word
  assign fifo_r_inc = !fifo_empty && (fifo_head.visible ? read_done : 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= fifo_r_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_r_inc) begin
      pixel.ctx   <= fifo_head;
      pixel.color <= fifo_head.visible ? rd_rsp.rdata : '0;
    end
  end

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo (
  input  logic                clk,
  input  logic                reset,
  input  logic                w_inc,
  input  vga_pkg::pixel_ctx_t w_data,
  output logic                w_full,
  output logic                w_almost_full,
  input  logic                r_inc,
  output vga_pkg::pixel_ctx_t r_data,
  output logic                r_empty
);

  vga_pkg::pixel_ctx_t mem [vga_pkg::FIFO_DEPTH];

  // one extra bit tells a full buffer from an empty one
  logic [vga_pkg::FIFO_ADDR_BITS:0] w_ptr;
  logic [vga_pkg::FIFO_ADDR_BITS:0] r_ptr;
  logic [vga_pkg::FIFO_ADDR_BITS:0] count;

  logic do_write;
  logic do_read;

  assign count    = w_ptr - r_ptr;
  assign do_write = w_inc && !w_full;
  assign do_read  = r_inc && !r_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (do_write) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (do_read) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_ptr[vga_pkg::FIFO_ADDR_BITS-1:0]] <= w_data;
    end
  end

  // head word is visible before the pop
  assign r_data = mem[r_ptr[vga_pkg::FIFO_ADDR_BITS-1:0]];

  assign r_empty = (w_ptr == r_ptr);
  assign w_full  = (count == vga_pkg::FIFO_DEPTH);

  // raised once fewer than FIFO_ALMOST_FULL_BUF slots are free
  assign w_almost_full = (count > vga_pkg::FIFO_DEPTH - vga_pkg::FIFO_ALMOST_FULL_BUF);

endmodule

// ==== source/vga_sync.sv ====
`timescale 1ns/1ps

module vga_sync (
  input  logic          clk,
  input  logic          reset,
  input  logic          enable,
  output logic          visible,
  output logic          hsync,
  output logic          vsync,
  output vga_pkg::col_t column,
  output vga_pkg::row_t row
);

  logic line_end;
  logic frame_end;

  assign line_end  = (column == vga_pkg::col_t'(vga_pkg::H_WHOLE_LINE - 1));
  assign frame_end = (row == vga_pkg::row_t'(vga_pkg::V_WHOLE_FRAME - 1));

  // column walks the line, row steps once per wrapped line
  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
      row    <= '0;
    end else if (enable) begin
      if (line_end) begin
        column <= '0;
        if (frame_end) begin
          row <= '0;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  // decode from the current position
  always_comb begin
    visible = (column < vga_pkg::H_VISIBLE) && (row < vga_pkg::V_VISIBLE);

    // both syncs are active low
    hsync = !((column >= vga_pkg::H_SYNC_START) && (column < vga_pkg::H_SYNC_END));
    vsync = !((row >= vga_pkg::V_SYNC_START) && (row < vga_pkg::V_SYNC_END));
  end

endmodule

// ==== source/vga_pkg.sv ====
package vga_pkg;

  // horizontal timing in pixels
  localparam int H_VISIBLE     = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE  = 3;
  localparam int H_BACK_PORCH  = 3;
  localparam int H_WHOLE_LINE  = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

  // vertical timing in lines
  localparam int V_VISIBLE     = 12;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 2;
  localparam int V_BACK_PORCH  = 1;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

  // sync pulse windows, end is exclusive
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

  localparam int FB_WORDS = H_VISIBLE * V_VISIBLE;

  // pixel context fifo
  localparam int FIFO_ADDR_BITS       = 3;
  localparam int FIFO_DEPTH           = 1 << FIFO_ADDR_BITS;
  localparam int FIFO_ALMOST_FULL_BUF = 2;

  // rgb444
  typedef logic [11:0] color_t;
  typedef logic [7:0]  fb_addr_t;
  typedef logic [4:0]  col_t;
  typedef logic [3:0]  row_t;

  // metadata that travels next to an outstanding read
  typedef struct packed {
    logic     visible;
    logic     vsync;
    logic     hsync;
    fb_addr_t addr;
  } pixel_ctx_t;

  typedef struct packed {
    pixel_ctx_t ctx;
    color_t     color;
  } pixel_out_t;

  typedef struct packed {
    fb_addr_t araddr;
    logic     arvalid;
  } fb_rd_req_t;

  typedef struct packed {
    color_t rdata;
    logic   rvalid;
  } fb_rd_rsp_t;

endpackage
